/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= lsu.f
BUILD_DIR ?= build
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the pass message shows up in the output
run: build
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /all tests passed/ { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* logic/axil_if.sv */
`default_nettype none

interface axil_if;

    // write address and data
    logic                        awvalid;
    logic                        awready;
    logic [lsu_pkg::xlen-1:0]    awaddr;
    logic                        wvalid;
    logic                        wready;
    logic [lsu_pkg::xlen-1:0]    wdata;
    logic [lsu_pkg::xlen/8-1:0]  wstrb;

    // write response
    logic                        bvalid;
    logic                        bready;
    logic [1:0]                  bresp;

    // read address and data
    logic                        arvalid;
    logic                        arready;
    logic [lsu_pkg::xlen-1:0]    araddr;
    logic                        rvalid;
    logic                        rready;
    logic [lsu_pkg::xlen-1:0]    rdata;
    logic [1:0]                  rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

/* logic/data_ram.sv */
`default_nettype none

module data_ram (
    input  logic   clk,
    input  logic   rst,
    axil_if.slave  bus
);

    logic [lsu_pkg::xlen-1:0]           mem [lsu_pkg::ram_words];
    logic [lsu_pkg::ram_index_bits-1:0] wr_idx;
    logic [lsu_pkg::ram_index_bits-1:0] rd_idx;
    logic                               wr_accept;
    logic                               rd_accept;
    logic                               bvalid_q;
    logic                               rvalid_q;
    logic [lsu_pkg::xlen-1:0]           rdata_q;

    // word index, byte offset bits dropped
    assign wr_idx = bus.awaddr[lsu_pkg::ram_index_bits+2:3];
    assign rd_idx = bus.araddr[lsu_pkg::ram_index_bits+2:3];

    assign bus.awready = wr_accept;
    assign bus.wready  = wr_accept;
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = lsu_pkg::axi_resp_okay;
    assign bus.arready = rd_accept;
    assign bus.rvalid  = rvalid_q;
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = lsu_pkg::axi_resp_okay;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < lsu_pkg::ram_words; i++) begin
                mem[i] <= '0;
            end
            wr_accept <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            // one-cycle ready pulse once address and data are both present
            wr_accept <= bus.awvalid && bus.wvalid && !wr_accept && !bvalid_q;
            if (wr_accept && bus.awvalid && bus.wvalid) begin
                for (int b = 0; b < lsu_pkg::xlen / 8; b++) begin
                    if (bus.wstrb[b]) begin
                        mem[wr_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                    end
                end
                bvalid_q <= 1'b1;
            end else if (bvalid_q && bus.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_accept <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            rd_accept <= bus.arvalid && !rd_accept && !rvalid_q;
            if (rd_accept && bus.arvalid) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && bus.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept && bus.arvalid) begin
            rdata_q <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // data and address width
    localparam int xlen = 64;

    // data RAM geometry, one entry per 64-bit word
    localparam int ram_words      = 64;
    localparam int ram_index_bits = 6;

    // load func3 codes, stores use the low two bits as size
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_ld  = 3'b011;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_lwu = 3'b110;

    // writeback source select
    localparam logic [1:0] sel_alu  = 2'd0;
    localparam logic [1:0] sel_load = 2'd1;
    localparam logic [1:0] sel_pc4  = 2'd2;

    localparam logic [1:0] axi_resp_okay = 2'b00;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] src2;
        logic [2:0]      func3;
        logic            mem_ren;
        logic            mem_wen;
        logic            reg_wen;
        logic [4:0]      rd;
        logic [1:0]      wreg_sel;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] load_data;
        logic [1:0]      wreg_sel;
        logic            reg_wen;
        logic [4:0]      rd;
    } mem_wb_t;

endpackage

`default_nettype wire

/* logic/lsu_top.sv */
`default_nettype none

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ex_valid,
    output logic                     ex_allowin,
    input  logic [lsu_pkg::xlen-1:0] ex_pc,
    input  logic [lsu_pkg::xlen-1:0] ex_alu_result,
    input  logic [lsu_pkg::xlen-1:0] ex_src2,
    input  logic [2:0]               ex_func3,
    input  logic                     ex_mem_ren,
    input  logic                     ex_mem_wen,
    input  logic                     ex_reg_wen,
    input  logic [4:0]               ex_rd,
    input  logic [1:0]               ex_wreg_sel,
    output logic                     wb_valid,
    input  logic                     wb_ready,
    output logic                     wb_wen,
    output logic [4:0]               wb_rd,
    output logic [lsu_pkg::xlen-1:0] wb_data
);

    lsu_pkg::ex_mem_t ex_op;
    lsu_pkg::mem_wb_t ms_to_ws_op;
    logic             ms_to_ws_valid;
    logic             ws_allowin;

    axil_if mem_bus ();

    assign ex_op.pc         = ex_pc;
    assign ex_op.alu_result = ex_alu_result;
    assign ex_op.src2       = ex_src2;
    assign ex_op.func3      = ex_func3;
    assign ex_op.mem_ren    = ex_mem_ren;
    assign ex_op.mem_wen    = ex_mem_wen;
    assign ex_op.reg_wen    = ex_reg_wen;
    assign ex_op.rd         = ex_rd;
    assign ex_op.wreg_sel   = ex_wreg_sel;

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (ex_valid),
        .in_allowin  (ex_allowin),
        .in_op       (ex_op),
        .out_valid   (ms_to_ws_valid),
        .out_allowin (ws_allowin),
        .out_op      (ms_to_ws_op),
        .mem         (mem_bus)
    );

    wb_stage u_wb_stage (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (ms_to_ws_valid),
        .in_allowin (ws_allowin),
        .in_op      (ms_to_ws_op),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_wen     (wb_wen),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    data_ram u_data_ram (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus)
    );

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`default_nettype none

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_allowin,
    input  lsu_pkg::ex_mem_t in_op,
    output logic             out_valid,
    input  logic             out_allowin,
    output lsu_pkg::mem_wb_t out_op,
    axil_if.master           mem
);

    typedef enum logic [1:0] {
        s_idle,
        s_req,
        s_wait,
        s_done
    } state_t;

    logic                       valid;
    lsu_pkg::ex_mem_t           op;
    state_t                     state;
    logic                       aw_done;
    logic                       w_done;
    logic                       ready_go;
    logic [lsu_pkg::xlen-1:0]   rdata_raw;
    logic [2:0]                 offset;
    logic [lsu_pkg::xlen-1:0]   shifted;
    logic [lsu_pkg::xlen-1:0]   load_ext;
    logic [lsu_pkg::xlen/8-1:0] strb;
    logic [lsu_pkg::xlen-1:0]   wdata;

    // nothing outstanding on the bus
    assign ready_go   = (state == s_idle) || (state == s_done);
    assign in_allowin = !valid || (ready_go && out_allowin);
    assign out_valid  = valid && ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op <= in_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= s_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (in_allowin) begin
            // new op replaces the finished one
            if (in_valid && (in_op.mem_ren || in_op.mem_wen)) begin
                state <= s_req;
            end else begin
                state <= s_idle;
            end
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                s_req: begin
                    if (op.mem_wen) begin
                        if (mem.awvalid && mem.awready) begin
                            aw_done <= 1'b1;
                        end
                        if (mem.wvalid && mem.wready) begin
                            w_done <= 1'b1;
                        end
                        // both channels may complete in different cycles
                        if ((aw_done || mem.awready) && (w_done || mem.wready)) begin
                            state <= s_wait;
                        end
                    end else if (mem.arready) begin
                        state <= s_wait;
                    end
                end
                s_wait: begin
                    if (op.mem_wen ? mem.bvalid : mem.rvalid) begin
                        state <= s_done;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_wait && !op.mem_wen && mem.rvalid) begin
            rdata_raw <= mem.rdata;
        end
    end

    assign offset = op.alu_result[2:0];

    // store lanes replicated across the word, strobe picks the bytes
    always_comb begin
        case (op.func3[1:0])
            lsu_pkg::f3_lb[1:0]: begin
                strb  = 8'h01 << offset;
                wdata = {8{op.src2[7:0]}};
            end
            lsu_pkg::f3_lh[1:0]: begin
                strb  = 8'h03 << offset;
                wdata = {4{op.src2[15:0]}};
            end
            lsu_pkg::f3_lw[1:0]: begin
                strb  = 8'h0f << offset;
                wdata = {2{op.src2[31:0]}};
            end
            default: begin
                strb  = 8'hff;
                wdata = op.src2;
            end
        endcase
    end

    assign mem.awvalid = (state == s_req) && op.mem_wen && !aw_done;
    assign mem.awaddr  = op.alu_result;
    assign mem.wvalid  = (state == s_req) && op.mem_wen && !w_done;
    assign mem.wdata   = wdata;
    assign mem.wstrb   = strb;
    assign mem.bready  = 1'b1;
    assign mem.arvalid = (state == s_req) && !op.mem_wen;
    assign mem.araddr  = op.alu_result;
    assign mem.rready  = 1'b1;

    // bring the addressed bytes down to bit 0
    assign shifted = rdata_raw >> {offset, 3'b000};

    always_comb begin
        case (op.func3)
            lsu_pkg::f3_lb:  load_ext = {{56{shifted[7]}}, shifted[7:0]};
            lsu_pkg::f3_lh:  load_ext = {{48{shifted[15]}}, shifted[15:0]};
            lsu_pkg::f3_lw:  load_ext = {{32{shifted[31]}}, shifted[31:0]};
            lsu_pkg::f3_ld:  load_ext = shifted;
            lsu_pkg::f3_lbu: load_ext = {56'd0, shifted[7:0]};
            lsu_pkg::f3_lhu: load_ext = {48'd0, shifted[15:0]};
            lsu_pkg::f3_lwu: load_ext = {32'd0, shifted[31:0]};
            default:         load_ext = shifted;
        endcase
    end

    always_comb begin
        out_op.pc         = op.pc;
        out_op.alu_result = op.alu_result;
        out_op.load_data  = load_ext;
        out_op.wreg_sel   = op.wreg_sel;
        out_op.reg_wen    = op.reg_wen;
        out_op.rd         = op.rd;
    end

endmodule

`default_nettype wire

/* logic/wb_stage.sv */
`default_nettype none

module wb_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_allowin,
    input  lsu_pkg::mem_wb_t         in_op,
    output logic                     wb_valid,
    input  logic                     wb_ready,
    output logic                     wb_wen,
    output logic [4:0]               wb_rd,
    output logic [lsu_pkg::xlen-1:0] wb_data
);

    logic             valid;
    lsu_pkg::mem_wb_t op;

    // entry leaves when the outside takes it
    assign in_allowin = !valid || wb_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op <= in_op;
        end
    end

    assign wb_valid = valid;
    assign wb_rd    = op.rd;

    // x0 is never written
    assign wb_wen = op.reg_wen && (op.rd != 5'd0);

    always_comb begin
        case (op.wreg_sel)
            lsu_pkg::sel_load: wb_data = op.load_data;
            lsu_pkg::sel_pc4:  wb_data = op.pc + 64'd4;
            default:           wb_data = op.alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* lsu.f */
logic/lsu_pkg.sv
logic/axil_if.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/data_ram.sv
logic/lsu_top.sv
sim/clk_gen.sv
sim/lsu_props.sv
sim/lsu_tb.sv

/* sim/clk_gen.sv */
`default_nettype none

module clk_gen (
    output logic clk
);

    // 100 time unit period
    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* sim/lsu_props.sv */
`default_nettype none

module lsu_props (
    input logic                     clk,
    input logic                     rst,
    input logic                     awvalid,
    input logic                     awready,
    input logic [lsu_pkg::xlen-1:0] awaddr,
    input logic                     wvalid,
    input logic                     wready,
    input logic [lsu_pkg::xlen-1:0] wdata,
    input logic                     arvalid,
    input logic                     arready,
    input logic [lsu_pkg::xlen-1:0] araddr,
    input logic                     bvalid,
    input logic                     rvalid,
    input logic [1:0]               size
);

    int unsigned fail_count = 0;

    // a raised valid holds with its payload until the ready
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("awvalid dropped or awaddr changed before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else begin
            $error("wvalid dropped or wdata changed before wready");
            fail_count++;
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid dropped or araddr changed before arready");
            fail_count++;
        end

    // synchronous reset, so valids are low one edge later
    reset_quiet: assert property (@(posedge clk)
        rst |=> !(awvalid || wvalid || arvalid || bvalid || rvalid))
        else begin
            $error("AXI valid high during reset");
            fail_count++;
        end

    addr_aligned: assert property (@(posedge clk) disable iff (rst)
        (awvalid || arvalid) |->
            ((awvalid ? awaddr : araddr) & ((64'd1 << size) - 64'd1)) == 64'd0)
        else begin
            $error("misaligned access address");
            fail_count++;
        end

    aw_w_together: assert property (@(posedge clk) disable iff (rst)
        $rose(awvalid) == $rose(wvalid))
        else begin
            $error("awvalid and wvalid did not rise together");
            fail_count++;
        end

endmodule

bind mem_stage lsu_props u_props (
    .clk     (clk),                 .rst     (rst),
    .awvalid (mem.awvalid),         .awready (mem.awready),  .awaddr (mem.awaddr),
    .wvalid  (mem.wvalid),          .wready  (mem.wready),   .wdata  (mem.wdata),
    .arvalid (mem.arvalid),         .arready (mem.arready),  .araddr (mem.araddr),
    .bvalid  (mem.bvalid),
    .rvalid  (mem.rvalid),
    .size    (op.func3[1:0])
);

// word-indexed RAM, no access size on this side
bind data_ram lsu_props u_props (
    .clk     (clk),                 .rst     (rst),
    .awvalid (bus.awvalid),         .awready (bus.awready),  .awaddr (bus.awaddr),
    .wvalid  (bus.wvalid),          .wready  (bus.wready),   .wdata  (bus.wdata),
    .arvalid (bus.arvalid),         .arready (bus.arready),  .araddr (bus.araddr),
    .bvalid  (bus.bvalid),
    .rvalid  (bus.rvalid),
    .size    (2'd0)
);

`default_nettype wire

/* sim/lsu_tb.sv */
`default_nettype none

module lsu_tb;

    typedef struct packed {
        logic                     wen;
        logic [4:0]               rd;
        logic [lsu_pkg::xlen-1:0] data;
    } wb_exp_t;

    localparam int n_basic     = 8;
    localparam int n_zero      = 1;
    localparam int n_rounds    = 4;
    localparam int n_mixed     = 30;
    localparam int n_stall     = 30;
    // each round is four stores and seven loads
    localparam int n_ops       = n_basic + n_zero + n_rounds * 11 + n_mixed + n_stall;
    localparam int cycle_limit = n_ops * 20 + 100;

    logic        clk;
    logic        rst;
    logic        ex_valid;
    logic        ex_allowin;
    logic [63:0] ex_pc;
    logic [63:0] ex_alu_result;
    logic [63:0] ex_src2;
    logic [2:0]  ex_func3;
    logic        ex_mem_ren;
    logic        ex_mem_wen;
    logic        ex_reg_wen;
    logic [4:0]  ex_rd;
    logic [1:0]  ex_wreg_sel;
    logic        wb_valid;
    logic        wb_ready = 1'b1;
    logic        wb_wen;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;

    logic        stall_mode = 1'b0;
    int          cycle_count = 0;
    int          backpressure_seen;
    logic        held_valid;
    logic        held_wen;
    logic [4:0]  held_rd;
    logic [63:0] held_data;
    logic [63:0] model_mem [lsu_pkg::ram_words];
    wb_exp_t     exp_q [$];

    clk_gen u_clk_gen (
        .clk (clk)
    );

    lsu_top uut (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_allowin    (ex_allowin),
        .ex_pc         (ex_pc),
        .ex_alu_result (ex_alu_result),
        .ex_src2       (ex_src2),
        .ex_func3      (ex_func3),
        .ex_mem_ren    (ex_mem_ren),
        .ex_mem_wen    (ex_mem_wen),
        .ex_reg_wen    (ex_reg_wen),
        .ex_rd         (ex_rd),
        .ex_wreg_sel   (ex_wreg_sel),
        .wb_valid      (wb_valid),
        .wb_ready      (wb_ready),
        .wb_wen        (wb_wen),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, want, got);
            stop_with_failure();
        end
    endtask

    // little-endian byte gather, then extension by func3
    function automatic logic [63:0] load_from_model(input logic [63:0] addr,
                                                    input logic [2:0] f3);
        logic [63:0] raw;
        logic [63:0] a;
        int          n;
        raw = '0;
        n   = 1 << f3[1:0];
        for (int b = 0; b < n; b++) begin
            a = addr + 64'(b);
            raw[b*8 +: 8] = model_mem[a[8:3]][{a[2:0], 3'b000} +: 8];
        end
        if (!f3[2] && n < 8) begin
            raw = raw | ({64{raw[n*8-1]}} << (n * 8));
        end
        return raw;
    endfunction

    task automatic store_to_model(input logic [63:0] addr, input logic [63:0] data,
                                  input logic [1:0] size);
        logic [63:0] a;
        for (int b = 0; b < (1 << size); b++) begin
            a = addr + 64'(b);
            model_mem[a[8:3]][{a[2:0], 3'b000} +: 8] = data[b*8 +: 8];
        end
    endtask

    function automatic logic [63:0] aligned_addr(input logic [1:0] size);
        logic [63:0] a;
        a = 64'($urandom % 512);
        return a & ~((64'd1 << size) - 64'd1);
    endfunction

    // presents one op and returns at the edge that takes it
    task automatic drive_op(input logic [63:0] pc, input logic [63:0] addr,
                            input logic [63:0] src2, input logic [2:0] f3,
                            input logic ren, input logic wen, input logic rwen,
                            input logic [4:0] rd, input logic [1:0] sel);
        @(negedge clk);
        ex_valid      = 1'b1;
        ex_pc         = pc;
        ex_alu_result = addr;
        ex_src2       = src2;
        ex_func3      = f3;
        ex_mem_ren    = ren;
        ex_mem_wen    = wen;
        ex_reg_wen    = rwen;
        ex_rd         = rd;
        ex_wreg_sel   = sel;
        @(posedge clk);
        while (!ex_allowin) begin
            @(posedge clk);
        end
    endtask

    task automatic random_op();
        logic [1:0]  kind;
        logic [2:0]  f3;
        logic [63:0] pc;
        logic [4:0]  rd;
        kind = 2'($urandom % 4);
        f3   = 3'($urandom % 7);
        pc   = {$urandom, $urandom} & ~64'd3;
        rd   = 5'($urandom);
        case (kind)
            2'd0: drive_op(pc, {$urandom, $urandom}, 64'd0, f3, 1'b0, 1'b0, 1'b1, rd,
                           lsu_pkg::sel_alu);
            2'd1: drive_op(pc, {$urandom, $urandom}, 64'd0, f3, 1'b0, 1'b0, 1'b1, rd,
                           lsu_pkg::sel_pc4);
            2'd2: drive_op(pc, aligned_addr(f3[1:0]), {$urandom, $urandom}, {1'b0, f3[1:0]},
                           1'b0, 1'b1, 1'b0, rd, lsu_pkg::sel_alu);
            default: drive_op(pc, aligned_addr(f3[1:0]), 64'd0, f3, 1'b1, 1'b0, 1'b1, rd,
                              lsu_pkg::sel_load);
        endcase
    endtask

    // overlapping stores into one word, then every load width back out of it
    task automatic store_load_round();
        logic [63:0] base;
        logic [63:0] off;
        base = 64'($urandom % 64) << 3;
        for (int s = 0; s < 4; s++) begin
            off = 64'($urandom % 8) & ~((64'd1 << s) - 64'd1);
            drive_op(64'h2000, base + off, {$urandom, $urandom}, 3'(s), 1'b0, 1'b1, 1'b0,
                     5'(s), lsu_pkg::sel_alu);
        end
        for (int f = 0; f < 7; f++) begin
            off = 64'($urandom % 8) & ~((64'd1 << f[1:0]) - 64'd1);
            drive_op(64'h2100, base + off, 64'd0, 3'(f), 1'b1, 1'b0, 1'b1, 5'(f + 8),
                     lsu_pkg::sel_load);
        end
    endtask

    always @(negedge clk) begin
        if (stall_mode) begin
            wb_ready = ($urandom % 3) != 0;
        end else begin
            wb_ready = 1'b1;
        end
    end

    // expectations at the issue handshake, checks at the retire handshake
    always @(posedge clk) begin
        wb_exp_t     e;
        logic [63:0] ld;
        if (rst) begin
            for (int i = 0; i < lsu_pkg::ram_words; i++) begin
                model_mem[i] = '0;
            end
            held_valid        = 1'b0;
            backpressure_seen = 0;
        end else begin
            // mem stage holds an op behind the stalled writeback
            if (wb_valid && !wb_ready && exp_q.size() > 1) begin
                check_value("ex_allowin", 64'(ex_allowin), 64'd0);
                backpressure_seen++;
            end
            if (ex_valid && ex_allowin) begin
                ld = '0;
                if (ex_mem_wen) begin
                    store_to_model(ex_alu_result, ex_src2, ex_func3[1:0]);
                end
                if (ex_mem_ren) begin
                    ld = load_from_model(ex_alu_result, ex_func3);
                end
                e.wen = ex_reg_wen && (ex_rd != 5'd0);
                e.rd  = ex_rd;
                case (ex_wreg_sel)
                    lsu_pkg::sel_load: e.data = ld;
                    lsu_pkg::sel_pc4:  e.data = ex_pc + 64'd4;
                    default:           e.data = ex_alu_result;
                endcase
                exp_q.push_back(e);
            end
            if (held_valid) begin
                check_value("wb_valid", 64'(wb_valid), 64'd1);
                check_value("wb_wen", 64'(wb_wen), 64'(held_wen));
                check_value("wb_rd", 64'(wb_rd), 64'(held_rd));
                check_value("wb_data", wb_data, held_data);
            end
            if (wb_valid && wb_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("writeback retired with nothing expected at %0t", $time);
                    stop_with_failure();
                end
                e = exp_q.pop_front();
                check_value("wb_wen", 64'(wb_wen), 64'(e.wen));
                check_value("wb_rd", 64'(wb_rd), 64'(e.rd));
                check_value("wb_data", wb_data, e.data);
            end
            held_valid = wb_valid && !wb_ready;
            held_wen   = wb_wen;
            held_rd    = wb_rd;
            held_data  = wb_data;
            assert (uut.u_mem_stage.u_props.fail_count == 0 &&
                    uut.u_data_ram.u_props.fail_count == 0) else begin
                $display("an AXI4-Lite protocol property failed");
                stop_with_failure();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        void'($urandom(52));
        rst           = 1'b1;
        ex_valid      = 1'b0;
        ex_pc         = '0;
        ex_alu_result = '0;
        ex_src2       = '0;
        ex_func3      = '0;
        ex_mem_ren    = 1'b0;
        ex_mem_wen    = 1'b0;
        ex_reg_wen    = 1'b0;
        ex_rd         = '0;
        ex_wreg_sel   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle pipeline after reset
        repeat (2) @(negedge clk);
        check_value("ex_allowin", 64'(ex_allowin), 64'd1);
        check_value("wb_valid", 64'(wb_valid), 64'd0);

        // never-written word reads back as zero
        drive_op(64'h1ffc, 64'h1f8, 64'd0, lsu_pkg::f3_ld, 1'b1, 1'b0, 1'b1, 5'd7,
                 lsu_pkg::sel_load);

        for (int i = 0; i < n_basic; i++) begin
            drive_op(64'h1000 + 64'(i * 4), {$urandom, $urandom}, 64'd0, 3'd0,
                     1'b0, 1'b0, 1'b1, (i % 3 == 0) ? 5'd0 : 5'(i),
                     (i % 2 == 0) ? lsu_pkg::sel_alu : lsu_pkg::sel_pc4);
        end
        for (int r = 0; r < n_rounds; r++) begin
            store_load_round();
        end
        for (int i = 0; i < n_mixed; i++) begin
            random_op();
        end

        stall_mode = 1'b1;
        for (int i = 0; i < n_stall; i++) begin
            random_op();
        end
        @(negedge clk);
        ex_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        assert (backpressure_seen > 0) else begin
            $display("back-pressure never lowered ex_allowin");
            stop_with_failure();
        end

        if (!wb_valid) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("writeback still pending after the expected ones drained");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
